//--- vram_pkg.sv
package vram_pkg;

    // cpu side word and address widths
    localparam int WORD_WIDTH      = 16;
    localparam int VRAM_ADDR_WIDTH = 13;

    // 23lc1024 takes a 24-bit byte address
    localparam int SRAM_ADDR_WIDTH = 24;

    // serial sram instruction bytes
    localparam logic [7:0] CMD_RSTIO = 8'hFF;
    localparam logic [7:0] CMD_EQIO  = 8'h38;
    localparam logic [7:0] CMD_WRITE = 8'h02;
    localparam logic [7:0] CMD_READ  = 8'h03;

    // top left corner of the screen window in raster coordinates
    localparam logic [9:0] SCREEN_H_OFFSET = 10'd8;
    localparam logic [9:0] SCREEN_V_OFFSET = 10'd1;

    // one queued cpu write
    typedef struct packed {
        logic [VRAM_ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0]      data;
    } wr_req_t;

    // pins toward the sram
    typedef struct packed {
        logic       cs_n;
        logic       sck;
        logic       oe;
        logic [3:0] sio;
    } sqi_out_t;

    // one nibble captured during a line read
    typedef struct packed {
        logic       valid;
        logic [3:0] data;
    } rd_nibble_t;

endpackage

//--- vram_write_queue.sv
`timescale 1ns/1ns

module vram_write_queue #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic [vram_pkg::VRAM_ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [vram_pkg::WORD_WIDTH-1:0]      wb_dat_i,
    output logic                                 wb_ack_o,
    input  logic                                 wr_pop_i,
    output logic                                 wr_valid_o,
    output vram_pkg::wr_req_t                    wr_req_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    vram_pkg::wr_req_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count == CNT_W'(FIFO_DEPTH));

    // the master still holds stb in the cycle it sees the ack
    assign push = wb_cyc_i && wb_stb_i && !full && !wb_ack_o;
    assign pop  = wr_pop_i && wr_valid_o;

    assign wr_valid_o = (count != '0);
    assign wr_req_o   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr].addr <= wb_adr_i;
            mem[wr_ptr].data <= wb_dat_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wb_ack_o <= 1'b0;
        end else begin
            // ack follows the accepted write by one clock
            wb_ack_o <= push;

            if (push) begin
                if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end

            if (pop) begin
                if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end

            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- line_fetcher.sv
`timescale 1ns/1ns

module line_fetcher #(
    parameter int LINE_WORDS   = 2,
    parameter int SCREEN_LINES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [9:0]           hpos_i,
    input  logic [9:0]           vpos_i,
    input  logic                 display_active_i,
    output logic                 fetch_req_o,
    output logic [9:0]           fetch_line_o,
    input  logic                 fetch_start_i,
    input  vram_pkg::rd_nibble_t rd_nibble_i,
    output logic                 pixel_o
);

    localparam int WIN_COLS = LINE_WORDS * vram_pkg::WORD_WIDTH;
    localparam int WIDX_W   = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

    // two line buffers, indexed by screen line parity
    logic [vram_pkg::WORD_WIDTH-1:0] line_buf [2][LINE_WORDS];

    logic [9:0]                      next_line;
    logic                            trigger;
    logic [1:0]                      nib_cnt;
    logic [WIDX_W-1:0]               word_cnt;
    logic [11:0]                     nib_acc;
    logic [9:0]                      col;
    logic [9:0]                      row;
    logic                            in_col;
    logic                            in_row;
    logic [vram_pkg::WORD_WIDTH-1:0] pix_word;

    // fetch on the raster line just before each screen line
    assign next_line = vpos_i + 10'd1;
    assign trigger   = (hpos_i == '0)
                    && (next_line >= vram_pkg::SCREEN_V_OFFSET)
                    && (next_line < vram_pkg::SCREEN_V_OFFSET + 10'(SCREEN_LINES));

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_req_o <= 1'b0;
        end else if (trigger) begin
            fetch_req_o <= 1'b1;
        end else if (fetch_start_i) begin
            fetch_req_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (trigger) begin
            fetch_line_o <= next_line - vram_pkg::SCREEN_V_OFFSET;
        end
    end

    // nibble and word position inside the incoming line
    always_ff @(posedge clk) begin
        if (reset || fetch_start_i) begin
            nib_cnt  <= '0;
            word_cnt <= '0;
        end else if (rd_nibble_i.valid) begin
            nib_cnt <= nib_cnt + 1'b1;
            if (nib_cnt == 2'd3) begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    // msb nibble arrives first
    always_ff @(posedge clk) begin
        if (rd_nibble_i.valid) begin
            nib_acc <= {nib_acc[7:0], rd_nibble_i.data};
            if (nib_cnt == 2'd3) begin
                line_buf[fetch_line_o[0]][word_cnt] <= {nib_acc, rd_nibble_i.data};
            end
        end
    end

    assign col    = hpos_i - vram_pkg::SCREEN_H_OFFSET;
    assign row    = vpos_i - vram_pkg::SCREEN_V_OFFSET;
    assign in_col = (hpos_i >= vram_pkg::SCREEN_H_OFFSET)
                 && (hpos_i < vram_pkg::SCREEN_H_OFFSET + 10'(WIN_COLS));
    assign in_row = (vpos_i >= vram_pkg::SCREEN_V_OFFSET)
                 && (vpos_i < vram_pkg::SCREEN_V_OFFSET + 10'(SCREEN_LINES));

    assign pix_word = line_buf[row[0]][col[4 +: WIDX_W]];

    // pixels are stored inverted
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_o <= 1'b0;
        end else begin
            pixel_o <= display_active_i && in_col && in_row && !pix_word[col[3:0]];
        end
    end

endmodule

//--- sqi_sram_engine.sv
`timescale 1ns/1ns

module sqi_sram_engine #(
    parameter int LINE_WORDS = 2
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_valid_i,
    input  vram_pkg::wr_req_t    wr_req_i,
    output logic                 wr_pop_o,
    input  logic                 fetch_req_i,
    input  logic [9:0]           fetch_line_i,
    output logic                 fetch_start_o,
    output vram_pkg::rd_nibble_t rd_nibble_o,
    input  logic [3:0]           sio_i,
    output vram_pkg::sqi_out_t   sqi_o,
    output logic                 initialized_o
);

    // command, address and dummy clocks ahead of read data
    localparam int READ_HDR_SCK = 10;
    localparam int READ_SCK     = READ_HDR_SCK + 4 * LINE_WORDS;
    localparam int WRITE_SCK    = 12;
    localparam int BOOT_SCK     = 8;
    localparam int CNT_W        = $clog2(READ_SCK + 1);
    localparam int SR_W         = 8 + vram_pkg::SRAM_ADDR_WIDTH + vram_pkg::WORD_WIDTH;

    typedef enum logic [2:0] {
        ST_RSTIO,
        ST_EQIO,
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t                               state;
    logic                                 cs_n_q;
    logic                                 sck_q;
    logic                                 oe_q;
    logic [CNT_W-1:0]                     sck_cnt;
    logic [CNT_W-1:0]                     frame_sck;
    logic [SR_W-1:0]                      sr;
    logic                                 rd_valid_q;
    logic [3:0]                           rd_data_q;
    logic                                 spi_mode;
    logic                                 boot_start;
    logic                                 sck_rise;
    logic                                 sck_fall;
    logic                                 frame_end;
    logic                                 capture;
    logic [7:0]                           boot_cmd;
    logic [vram_pkg::SRAM_ADDR_WIDTH-1:0] rd_addr;
    logic [vram_pkg::SRAM_ADDR_WIDTH-1:0] wr_addr;

    assign spi_mode = (state == ST_RSTIO) || (state == ST_EQIO);
    assign boot_cmd = (state == ST_RSTIO) ? vram_pkg::CMD_RSTIO : vram_pkg::CMD_EQIO;

    // line read wins over a queued write
    assign fetch_start_o = (state == ST_IDLE) && fetch_req_i;
    assign wr_pop_o      = (state == ST_IDLE) && !fetch_req_i && wr_valid_i;
    assign boot_start    = cs_n_q && spi_mode;

    always_comb begin
        case (state)
            ST_READ:  frame_sck = CNT_W'(READ_SCK);
            ST_WRITE: frame_sck = CNT_W'(WRITE_SCK);
            default:  frame_sck = CNT_W'(BOOT_SCK);
        endcase
    end

    assign sck_rise  = !cs_n_q && !sck_q;
    assign frame_end = !cs_n_q && sck_q && (sck_cnt == frame_sck);
    assign sck_fall  = !cs_n_q && sck_q && !frame_end;
    assign capture   = sck_rise && (state == ST_READ) && (sck_cnt >= CNT_W'(READ_HDR_SCK));

    // byte addresses, two bytes per word
    assign rd_addr = vram_pkg::SRAM_ADDR_WIDTH'(fetch_line_i)
                   * vram_pkg::SRAM_ADDR_WIDTH'(LINE_WORDS * 2);
    assign wr_addr = vram_pkg::SRAM_ADDR_WIDTH'({wr_req_i.addr, 1'b0});

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_RSTIO;
            cs_n_q        <= 1'b1;
            sck_q         <= 1'b0;
            oe_q          <= 1'b1;
            sck_cnt       <= '0;
            rd_valid_q    <= 1'b0;
            initialized_o <= 1'b0;
        end else begin
            rd_valid_q <= capture;

            if (boot_start || fetch_start_o || wr_pop_o) begin
                cs_n_q  <= 1'b0;
                sck_cnt <= '0;
            end
            if (fetch_start_o) begin
                state <= ST_READ;
            end else if (wr_pop_o) begin
                state <= ST_WRITE;
            end

            if (sck_rise) begin
                sck_q   <= 1'b1;
                sck_cnt <= sck_cnt + 1'b1;
            end

            if (sck_fall) begin
                sck_q <= 1'b0;
                // turn the bus around for the data phase
                if (state == ST_READ && sck_cnt == CNT_W'(READ_HDR_SCK)) begin
                    oe_q <= 1'b0;
                end
            end

            if (frame_end) begin
                sck_q  <= 1'b0;
                cs_n_q <= 1'b1;
                oe_q   <= 1'b1;
                case (state)
                    ST_RSTIO: state <= ST_EQIO;
                    ST_EQIO: begin
                        state         <= ST_IDLE;
                        initialized_o <= 1'b1;
                    end
                    default:  state <= ST_IDLE;
                endcase
            end
        end
    end

    // shift buffer and read capture
    always_ff @(posedge clk) begin
        if (boot_start) begin
            sr <= {boot_cmd, (SR_W - 8)'(0)};
        end else if (fetch_start_o) begin
            sr <= {vram_pkg::CMD_READ, rd_addr, (SR_W - 8 - vram_pkg::SRAM_ADDR_WIDTH)'(0)};
        end else if (wr_pop_o) begin
            sr <= {vram_pkg::CMD_WRITE, wr_addr, wr_req_i.data};
        end else if (sck_fall) begin
            sr <= spi_mode ? {sr[SR_W-2:0], 1'b0} : {sr[SR_W-5:0], 4'h0};
        end

        if (capture) begin
            rd_data_q <= sio_i;
        end
    end

    assign rd_nibble_o.valid = rd_valid_q;
    assign rd_nibble_o.data  = rd_data_q;

    assign sqi_o.cs_n = cs_n_q;
    assign sqi_o.sck  = sck_q;
    assign sqi_o.oe   = oe_q;
    // spi mode keeps hold_n high and sends on sio0
    assign sqi_o.sio  = spi_mode ? {1'b1, 2'b00, sr[SR_W-1]} : sr[SR_W-1 -: 4];

endmodule

//--- spi_video_ram.sv
`timescale 1ns/1ns

module spi_video_ram #(
    parameter int FIFO_DEPTH   = 4,
    parameter int LINE_WORDS   = 2,
    parameter int SCREEN_LINES = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic [vram_pkg::VRAM_ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [vram_pkg::WORD_WIDTH-1:0]      wb_dat_i,
    output logic                                 wb_ack_o,
    input  logic [9:0]                           hpos_i,
    input  logic [9:0]                           vpos_i,
    input  logic                                 display_active_i,
    output logic                                 pixel_o,
    input  logic [3:0]                           sio_i,
    output vram_pkg::sqi_out_t                   sqi_o,
    output logic                                 initialized_o
);

    // write queue to engine
    logic                 wr_valid;
    vram_pkg::wr_req_t    wr_req;
    logic                 wr_pop;

    // line fetcher to engine
    logic                 fetch_req;
    logic [9:0]           fetch_line;
    logic                 fetch_start;
    vram_pkg::rd_nibble_t rd_nibble;

    vram_write_queue #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_write_queue (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o),
        .wr_pop_i   (wr_pop),
        .wr_valid_o (wr_valid),
        .wr_req_o   (wr_req)
    );

    line_fetcher #(
        .LINE_WORDS   (LINE_WORDS),
        .SCREEN_LINES (SCREEN_LINES)
    ) u_line_fetcher (
        .clk              (clk),
        .reset            (reset),
        .hpos_i           (hpos_i),
        .vpos_i           (vpos_i),
        .display_active_i (display_active_i),
        .fetch_req_o      (fetch_req),
        .fetch_line_o     (fetch_line),
        .fetch_start_i    (fetch_start),
        .rd_nibble_i      (rd_nibble),
        .pixel_o          (pixel_o)
    );

    sqi_sram_engine #(
        .LINE_WORDS (LINE_WORDS)
    ) u_engine (
        .clk           (clk),
        .reset         (reset),
        .wr_valid_i    (wr_valid),
        .wr_req_i      (wr_req),
        .wr_pop_o      (wr_pop),
        .fetch_req_i   (fetch_req),
        .fetch_line_i  (fetch_line),
        .fetch_start_o (fetch_start),
        .rd_nibble_o   (rd_nibble),
        .sio_i         (sio_i),
        .sqi_o         (sqi_o),
        .initialized_o (initialized_o)
    );

endmodule

//--- sram_quad_model.sv
`timescale 1ns/1ns

module sram_quad_model (
    input  logic       cs_n_i,
    input  logic       sck_i,
    input  logic [3:0] sio_i,
    output logic [3:0] sio_o
);

    logic [7:0]  mem [16384];
    logic [7:0]  cmd_log [64];
    int          cmd_count;
    int          write_count;
    logic        quad;
    int          rise_cnt;
    int          idx;
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [13:0] byte_addr;
    int          rd_idx;
    logic [13:0] rd_byte_addr;

    initial begin
        quad        = 1'b0;
        cmd_count   = 0;
        write_count = 0;
        sio_o       = 4'h0;
        for (int i = 0; i < 16384; i++) begin
            mem[i] = 8'h00;
        end
    end

    // a falling cs finds sck low and starts a new command
    always @(negedge cs_n_i or posedge sck_i) begin
        if (!sck_i) begin
            rise_cnt = 0;
            cmd      = 8'h00;
            addr     = 24'h0;
        end else if (!cs_n_i) begin
            rise_cnt = rise_cnt + 1;
            if (!quad) begin
                // spi mode shifts one bit per clock on sio0
                cmd = {cmd[6:0], sio_i[0]};
                if (rise_cnt == 8) begin
                    if (cmd_count < 64) cmd_log[cmd_count] = cmd;
                    cmd_count = cmd_count + 1;
                    if (cmd == vram_pkg::CMD_EQIO) quad = 1'b1;
                end
            end else if (rise_cnt <= 2) begin
                cmd = {cmd[3:0], sio_i};
                if (rise_cnt == 2) begin
                    if (cmd_count < 64) cmd_log[cmd_count] = cmd;
                    cmd_count = cmd_count + 1;
                end
            end else if (rise_cnt <= 8) begin
                addr = {addr[19:0], sio_i};
            end else if (cmd == vram_pkg::CMD_WRITE) begin
                idx       = rise_cnt - 9;
                byte_addr = addr[13:0] + 14'(idx / 2);
                if (idx % 2 == 0) begin
                    mem[byte_addr][7:4] = sio_i;
                end else begin
                    mem[byte_addr][3:0] = sio_i;
                end
                if (rise_cnt == 12) write_count = write_count + 1;
            end
        end
    end

    // read data follows the two dummy clocks with the high nibble first
    always @(negedge sck_i) begin
        if (!cs_n_i && quad && cmd == vram_pkg::CMD_READ && rise_cnt >= 10) begin
            rd_idx       = rise_cnt - 10;
            rd_byte_addr = addr[13:0] + 14'(rd_idx / 2);
            sio_o = (rd_idx % 2 == 0) ? mem[rd_byte_addr][7:4] : mem[rd_byte_addr][3:0];
        end
    end

endmodule

//--- tb_spi_video_ram.sv
`timescale 1ns/1ns

module tb_spi_video_ram;

    logic                                 clk;
    logic                                 reset;
    logic                                 wb_cyc;
    logic                                 wb_stb;
    logic [vram_pkg::VRAM_ADDR_WIDTH-1:0] wb_adr;
    logic [vram_pkg::WORD_WIDTH-1:0]      wb_dat;
    logic                                 wb_ack;
    logic [9:0]                           hpos;
    logic [9:0]                           vpos;
    logic                                 active;
    logic                                 pixel;
    logic [3:0]                           sram_sio;
    vram_pkg::sqi_out_t                   sqi;
    logic                                 initialized;

    vram_pkg::wr_req_t writes [$];
    logic [31:0]       e_words [4];
    int                err_count;
    int                fail_count;
    int                cycles;
    int                limit;
    int                ack_count;
    int                stalls;
    logic              check_req;
    logic              checking;
    logic              check_done;

    spi_video_ram dut (
        .clk              (clk),
        .reset            (reset),
        .wb_cyc_i         (wb_cyc),
        .wb_stb_i         (wb_stb),
        .wb_adr_i         (wb_adr),
        .wb_dat_i         (wb_dat),
        .wb_ack_o         (wb_ack),
        .hpos_i           (hpos),
        .vpos_i           (vpos),
        .display_active_i (active),
        .pixel_o          (pixel),
        .sio_i            (sram_sio),
        .sqi_o            (sqi),
        .initialized_o    (initialized)
    );

    sram_quad_model model (
        .cs_n_i (sqi.cs_n),
        .sck_i  (sqi.sck),
        .sio_i  (sqi.sio),
        .sio_o  (sram_sio)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
            err_count++;
        end
    endtask

    // compares one queued write with the model memory holding the high byte first
    task automatic check_word(input vram_pkg::wr_req_t exp);
        logic [13:0] ba;
        logic [15:0] got;
        ba  = {exp.addr, 1'b0};
        got = {model.mem[ba], model.mem[ba + 14'd1]};
        if (got !== exp.data) begin
            $display("ERR %0t mem[%04h] got %04h expected %04h",
                     $time, exp.addr, got, exp.data);
            err_count++;
        end
    endtask

    function automatic logic expected_pixel(input int h, input int v, input logic act);
        if (act && h >= 8 && h < 40 && v >= 1 && v < 5) begin
            return ~e_words[v - 1][h - 8];
        end
        return 1'b0;
    endfunction

    task automatic read_golden();
        int                fd;
        int                code;
        string             line;
        logic [31:0]       a;
        logic [31:0]       d;
        vram_pkg::wr_req_t req;
        fd = $fopen("vram_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open vram_golden.txt");
            fail_count++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin
                code = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
                if (line.getc(0) == "W") begin
                    req.addr = a[12:0];
                    req.data = d[15:0];
                    writes.push_back(req);
                end else if (line.getc(0) == "E") begin
                    e_words[a[1:0]] = d;
                end
            end
        end
        $fclose(fd);
    endtask

    // back to back writes with the next word presented as soon as the ack is seen
    task automatic issue_writes();
        int i;
        i = 0;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_adr = writes[0].addr;
        wb_dat = writes[0].data;
        while (i < writes.size()) begin
            @(posedge clk);
            #1;
            if (wb_ack) begin
                i++;
                if (i < writes.size()) begin
                    wb_adr = writes[i].addr;
                    wb_dat = writes[i].data;
                end else begin
                    wb_cyc = 1'b0;
                    wb_stb = 1'b0;
                end
            end else begin
                stalls++;
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (wb_ack) ack_count++;
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // 64 x 8 raster with each pixel checked one clock after its coordinates
    initial begin
        int ph;
        int pv;
        logic pa;
        hpos   = '0;
        vpos   = '0;
        active = 1'b1;
        forever begin
            ph = int'(hpos);
            pv = int'(vpos);
            pa = active;
            @(posedge clk);
            #1;
            if (checking) check_bit("pixel_o", pixel, expected_pixel(ph, pv, pa));
            if (hpos == 10'd63) begin
                hpos = '0;
                vpos = (vpos == 10'd7) ? 10'd0 : vpos + 10'd1;
            end else begin
                hpos = hpos + 10'd1;
            end
            active = (hpos < 10'd48) && (vpos < 10'd7);
            if (hpos == '0 && vpos == '0) begin
                if (checking) begin
                    checking   = 1'b0;
                    check_done = 1'b1;
                end else if (check_req) begin
                    checking = 1'b1;
                end
            end
        end
    end

    initial begin
        err_count  = 0;
        fail_count = 0;
        cycles     = 0;
        limit      = 0;
        ack_count  = 0;
        stalls     = 0;
        check_req  = 1'b0;
        checking   = 1'b0;
        check_done = 1'b0;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_adr     = '0;
        wb_dat     = '0;
        read_golden();
        limit = 3 * 512 + 200 * writes.size() + 500;

        repeat (4) @(posedge clk);
        #1;
        check_bit("sqi_o.cs_n", sqi.cs_n, 1'b1);
        check_bit("sqi_o.oe", sqi.oe, 1'b1);
        check_bit("initialized_o", initialized, 1'b0);
        reset = 1'b0;

        while (!initialized) begin
            @(posedge clk);
            #1;
        end
        if (model.cmd_count != 2) begin
            $display("start-up sent %0d commands before initialized_o rose", model.cmd_count);
            fail_count++;
        end
        check_byte("boot cmd 0", model.cmd_log[0], vram_pkg::CMD_RSTIO);
        check_byte("boot cmd 1", model.cmd_log[1], vram_pkg::CMD_EQIO);

        issue_writes();
        if (stalls <= writes.size()) begin
            $display("write queue never held back the master, only %0d waits", stalls);
            fail_count++;
        end
        while (model.write_count < writes.size()) @(posedge clk);
        while (!sqi.cs_n) @(posedge clk);
        if (ack_count != writes.size()) begin
            $display("saw %0d acks for %0d writes", ack_count, writes.size());
            fail_count++;
        end
        foreach (writes[i]) check_word(writes[i]);

        check_req = 1'b1;
        while (!check_done) @(posedge clk);
        finish_run();
    end

endmodule

//--- vram_golden.txt
# W <word address> <data>, a cpu write
# E <screen line> <expected pixel word>, bit c is window column c
W 0000 A5F0
W 0001 0FF0
W 0002 1234
W 0003 8001
W 0004 FFFF
W 0005 0000
W 0006 C3C3
W 0007 5A5A
W 0100 BEEF
W 1FFF 7E81
E 0 0FF0A5F0
E 1 80011234
E 2 0000FFFF
E 3 5A5AC3C3

//--- files.f
vram_pkg.sv
vram_write_queue.sv
line_fetcher.sv
sqi_sram_engine.sv
spi_video_ram.sv
sram_quad_model.sv
tb_spi_video_ram.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_spi_video_ram -f files.f -o sim
./obj_dir/sim > sim.log
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
